/* verilog/pac_pkg.sv */
package pac_pkg;

    ////////////////////////////////////////
    // screen geometry and motion

    typedef logic [9:0] coord_t;
    typedef logic signed [9:0] step_t;

    localparam step_t STEP_POS  = 10'sd1;
    localparam step_t STEP_NEG  = -10'sd1;
    localparam step_t STEP_NONE = 10'sd0;

    localparam int SPRITE_HALF = 8;
    // playfield columns with the max excluded
    localparam int FIELD_X_MIN = 96;
    localparam int FIELD_X_MAX = 544;

    localparam int ANIM_PERIOD = 40;
    localparam int ANIM_HALF   = 20;

    localparam int FRIGHT_WIDTH        = 8;
    localparam int ALT_FRAME_RED_SHIFT = 1;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } sprite_pos_t;

    typedef struct packed {
        step_t dx;
        step_t dy;
        step_t dx_next;
        step_t dy_next;
    } hero_motion_t;

    // prev is the last non-zero motion, used when the ghost stops
    typedef struct packed {
        step_t dx;
        step_t dy;
        step_t dx_next;
        step_t dy_next;
        step_t dx_prev;
        step_t dy_prev;
    } ghost_motion_t;

    ////////////////////////////////////////
    // sprite kinds and colours

    typedef enum logic [3:0] {
        hero_right, hero_left, hero_up, hero_down,
        ghost_right, ghost_left, ghost_up, ghost_down, ghost_scared,
        end_screen, field, blank
    } sprite_kind_t;

    typedef struct packed {
        logic         hit;
        sprite_kind_t kind;
        logic         alt_frame;
    } sprite_hit_t;

    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgb_t;

    // one flat colour per kind in slightly different shades per direction
    localparam rgb_t kind_color [16] = '{
        hero_right:   '{4'hf, 4'hf, 4'h0},
        hero_left:    '{4'hf, 4'he, 4'h0},
        hero_up:      '{4'he, 4'hf, 4'h0},
        hero_down:    '{4'hf, 4'hd, 4'h1},
        ghost_right:  '{4'hf, 4'h0, 4'h0},
        ghost_left:   '{4'he, 4'h0, 4'h1},
        ghost_up:     '{4'hf, 4'h1, 4'h0},
        ghost_down:   '{4'hd, 4'h0, 4'h2},
        ghost_scared: '{4'h2, 4'h2, 4'hf},
        end_screen:   '{4'hf, 4'hf, 4'hf},
        field:        '{4'h0, 4'h0, 4'h8},
        default:      '{4'h0, 4'h0, 4'h0}
    };

    // strict box with no wrap at the screen edge
    function automatic logic in_sprite_box(sprite_pos_t draw, sprite_pos_t pos);
        logic [10:0] draw_x;
        logic [10:0] draw_y;
        logic [10:0] pos_x;
        logic [10:0] pos_y;
        draw_x = {1'b0, draw.x};
        draw_y = {1'b0, draw.y};
        pos_x  = {1'b0, pos.x};
        pos_y  = {1'b0, pos.y};
        return (draw_x + 11'(SPRITE_HALF) > pos_x) && (draw_x < pos_x + 11'(SPRITE_HALF))
            && (draw_y + 11'(SPRITE_HALF) > pos_y) && (draw_y < pos_y + 11'(SPRITE_HALF));
    endfunction

endpackage

/* verilog/fright_timer_bank.sv */
`timescale 1ns/1ns

module fright_timer_bank
#(
    parameter int NUM_GHOSTS    = 4,
    parameter int FRIGHT_FRAMES = 250
)
(
    input  logic                                             frame_clk,
    input  logic                                             reset,
    input  logic                                             power_pellet,
    input  logic [NUM_GHOSTS-1:0]                            capture,
    output logic [NUM_GHOSTS-1:0][pac_pkg::FRIGHT_WIDTH-1:0] fright
);
    import pac_pkg::*;

    localparam logic [FRIGHT_WIDTH-1:0] FRIGHT_LOAD = FRIGHT_WIDTH'(FRIGHT_FRAMES);

    for (genvar i = 0; i < NUM_GHOSTS; i++)
    begin : g_timer
        // pellet beats capture, capture beats countdown
        always_ff @(posedge frame_clk)
        begin
            if (reset)
                fright[i] <= '0;
            else if (power_pellet)
                fright[i] <= FRIGHT_LOAD;
            else if (capture[i])
                fright[i] <= '0;
            else if (fright[i] != '0)
                fright[i] <= fright[i] - 1'b1;
        end

        fright_in_range: assert property (
            @(posedge frame_clk) disable iff (reset)
            fright[i] <= FRIGHT_LOAD
        );
    end

endmodule

/* verilog/hero_sprite.sv */
`timescale 1ns/1ns

module hero_sprite
(
    input  logic                  frame_clk,
    input  logic                  reset,
    input  pac_pkg::sprite_pos_t  draw,
    input  pac_pkg::sprite_pos_t  hero,
    input  pac_pkg::hero_motion_t hero_motion,
    output pac_pkg::sprite_hit_t  hero_hit
);
    import pac_pkg::*;

    localparam int COUNT_WIDTH = $clog2(ANIM_PERIOD);

    logic [COUNT_WIDTH-1:0] anim_count;
    logic                   in_box;
    logic                   second_frame;

    ////////////////////////////////////////
    // mouth animation

    always_ff @(posedge frame_clk)
    begin
        if (reset)
            anim_count <= '0;
        else if (anim_count == COUNT_WIDTH'(ANIM_PERIOD - 1))
            anim_count <= '0;
        else
            anim_count <= anim_count + 1'b1;
    end

    assign second_frame = (anim_count >= COUNT_WIDTH'(ANIM_HALF));
    assign in_box       = in_sprite_box(draw, hero);

    ////////////////////////////////////////
    // horizontal facing wins over vertical

    always_comb
    begin
        hero_hit.hit       = in_box;
        hero_hit.alt_frame = second_frame;
        if (!in_box)
        begin
            hero_hit.kind      = blank;
            hero_hit.alt_frame = 1'b0;
        end
        else if (hero_motion.dx == STEP_POS || hero_motion.dx_next == STEP_POS)
            hero_hit.kind = hero_right;
        else if (hero_motion.dx == STEP_NEG || hero_motion.dx_next == STEP_NEG)
            hero_hit.kind = hero_left;
        else if (hero_motion.dy == STEP_NEG || hero_motion.dy_next == STEP_NEG)
            hero_hit.kind = hero_up;
        else if (hero_motion.dy == STEP_POS || hero_motion.dy_next == STEP_POS)
            hero_hit.kind = hero_down;
        else
        begin
            // mouth stays closed while standing still
            hero_hit.kind      = hero_down;
            hero_hit.alt_frame = 1'b0;
        end
    end

    anim_count_in_range: assert property (
        @(posedge frame_clk) disable iff (reset)
        anim_count < COUNT_WIDTH'(ANIM_PERIOD)
    );

endmodule

/* verilog/ghost_sprite.sv */
`timescale 1ns/1ns

module ghost_sprite
(
    input  pac_pkg::sprite_pos_t             draw,
    input  pac_pkg::sprite_pos_t             ghost,
    input  pac_pkg::ghost_motion_t           motion,
    input  logic [pac_pkg::FRIGHT_WIDTH-1:0] fright_time,
    output pac_pkg::sprite_hit_t             ghost_hit
);
    import pac_pkg::*;

    logic         in_box;
    logic         stopped;
    logic         facing_ok;
    sprite_kind_t facing;

    assign in_box  = in_sprite_box(draw, ghost);
    assign stopped = (motion.dx == STEP_NONE) && (motion.dy == STEP_NONE);

    ////////////////////////////////////////
    // facing when not frightened

    always_comb
    begin
        facing_ok = 1'b1;
        if (stopped)
        begin
            // keep looking the way it last moved
            if (motion.dx_prev == STEP_POS)
                facing = ghost_right;
            else if (motion.dx_prev == STEP_NEG)
                facing = ghost_left;
            else if (motion.dy_prev == STEP_POS)
                facing = ghost_down;
            else
                facing = ghost_up;
        end
        // vertical first for a moving ghost
        else if (motion.dy == STEP_POS || motion.dy_next == STEP_POS)
            facing = ghost_down;
        else if (motion.dy == STEP_NEG || motion.dy_next == STEP_NEG)
            facing = ghost_up;
        else if (motion.dx == STEP_NEG || motion.dx_next == STEP_NEG)
            facing = ghost_left;
        else if (motion.dx == STEP_POS || motion.dx_next == STEP_POS)
            facing = ghost_right;
        else
        begin
            // no legal step, nothing drawn
            facing    = blank;
            facing_ok = 1'b0;
        end
    end

    ////////////////////////////////////////
    // hit output

    always_comb
    begin
        ghost_hit.alt_frame = 1'b0;
        if (in_box && fright_time != '0)
        begin
            ghost_hit.hit  = 1'b1;
            ghost_hit.kind = ghost_scared;
        end
        else if (in_box && facing_ok)
        begin
            ghost_hit.hit  = 1'b1;
            ghost_hit.kind = facing;
        end
        else
        begin
            ghost_hit.hit  = 1'b0;
            ghost_hit.kind = blank;
        end
    end

endmodule

/* verilog/pixel_compositor.sv */
`timescale 1ns/1ns

module pixel_compositor
#(
    parameter int NUM_GHOSTS = 4
)
(
    input  pac_pkg::sprite_pos_t                  draw,
    input  logic                                  win,
    input  logic                                  lose,
    input  pac_pkg::sprite_hit_t                  hero_hit,
    input  pac_pkg::sprite_hit_t [NUM_GHOSTS-1:0] ghost_hit,
    output pac_pkg::rgb_t                         pixel
);
    import pac_pkg::*;

    logic         in_field;
    sprite_hit_t  ghost_top;
    sprite_kind_t layer_kind;
    logic         layer_alt;
    rgb_t         base_color;

    assign in_field = (draw.x >= coord_t'(FIELD_X_MIN)) && (draw.x < coord_t'(FIELD_X_MAX));

    ////////////////////////////////////////
    // lowest ghost index on top

    always_comb
    begin
        ghost_top = '{hit: 1'b0, kind: blank, alt_frame: 1'b0};
        // walk down so the lowest hit is written last
        for (int g = NUM_GHOSTS - 1; g >= 0; g--)
        begin
            if (ghost_hit[g].hit)
                ghost_top = ghost_hit[g];
        end
    end

    ////////////////////////////////////////
    // layer priority

    always_comb
    begin
        layer_alt = 1'b0;
        if ((win || lose) && in_field)
            layer_kind = end_screen;
        else if (hero_hit.hit)
        begin
            layer_kind = hero_hit.kind;
            layer_alt  = hero_hit.alt_frame;
        end
        else if (ghost_top.hit)
        begin
            layer_kind = ghost_top.kind;
            layer_alt  = ghost_top.alt_frame;
        end
        else if (in_field)
            layer_kind = field;
        else
            layer_kind = blank;
    end

    ////////////////////////////////////////
    // colour lookup

    assign base_color = kind_color[layer_kind];

    always_comb
    begin
        pixel = base_color;
        // second hero frame is a darker red
        if (layer_alt)
            pixel.red = base_color.red >> ALT_FRAME_RED_SHIFT;
    end

    // game ends one way only
    win_lose_exclusive: assert final (!(win === 1'b1 && lose === 1'b1));

endmodule

/* verilog/pacman_pixel_top.sv */
`timescale 1ns/1ns

module pacman_pixel_top
#(
    parameter int NUM_GHOSTS    = 4,
    parameter int FRIGHT_FRAMES = 250
)
(
    input  logic                                             frame_clk,
    input  logic                                             reset,
    input  pac_pkg::sprite_pos_t                             draw,
    input  pac_pkg::sprite_pos_t                             hero,
    input  pac_pkg::hero_motion_t                            hero_motion,
    input  pac_pkg::sprite_pos_t [NUM_GHOSTS-1:0]            ghost_pos,
    input  pac_pkg::ghost_motion_t [NUM_GHOSTS-1:0]          ghost_motion,
    input  logic                                             win,
    input  logic                                             lose,
    input  logic                                             power_pellet,
    input  logic [NUM_GHOSTS-1:0]                            capture,
    output pac_pkg::rgb_t                                    pixel,
    output logic [NUM_GHOSTS-1:0][pac_pkg::FRIGHT_WIDTH-1:0] fright
);
    import pac_pkg::*;

    sprite_hit_t                  hero_hit;
    sprite_hit_t [NUM_GHOSTS-1:0] ghost_hit;

    ////////////////////////////////////////
    // registered state

    fright_timer_bank
    #(
        .NUM_GHOSTS    (NUM_GHOSTS),
        .FRIGHT_FRAMES (FRIGHT_FRAMES)
    )
    u_fright_timer_bank
    (
        .frame_clk    (frame_clk),
        .reset        (reset),
        .power_pellet (power_pellet),
        .capture      (capture),
        .fright       (fright)
    );

    hero_sprite u_hero_sprite
    (
        .frame_clk   (frame_clk),
        .reset       (reset),
        .draw        (draw),
        .hero        (hero),
        .hero_motion (hero_motion),
        .hero_hit    (hero_hit)
    );

    ////////////////////////////////////////
    // one selector per ghost

    for (genvar g = 0; g < NUM_GHOSTS; g++)
    begin : g_ghost
        ghost_sprite u_ghost_sprite
        (
            .draw        (draw),
            .ghost       (ghost_pos[g]),
            .motion      (ghost_motion[g]),
            .fright_time (fright[g]),
            .ghost_hit   (ghost_hit[g])
        );
    end

    pixel_compositor
    #(
        .NUM_GHOSTS (NUM_GHOSTS)
    )
    u_pixel_compositor
    (
        .draw      (draw),
        .win       (win),
        .lose      (lose),
        .hero_hit  (hero_hit),
        .ghost_hit (ghost_hit),
        .pixel     (pixel)
    );

endmodule

/* bench/pixel_tb.sv */
`timescale 1ns/1ns

module pixel_tb;
    import pac_pkg::*;

    localparam int NG            = 4;
    localparam int FRIGHT_FRAMES = 250;
    localparam int DRAIN_LIMIT   = 2 * FRIGHT_FRAMES;

    logic                                frame_clk;
    logic                                reset;
    sprite_pos_t                         draw;
    sprite_pos_t                         hero;
    hero_motion_t                        hero_motion;
    sprite_pos_t [NG-1:0]                ghost_pos;
    ghost_motion_t [NG-1:0]              ghost_motion;
    logic                                win;
    logic                                lose;
    logic                                power_pellet;
    logic [NG-1:0]                       capture;
    rgb_t                                pixel;
    logic [NG-1:0][FRIGHT_WIDTH-1:0]     fright;

    // bench copies of the registered state
    int                                  anim_shadow;
    logic [NG-1:0][FRIGHT_WIDTH-1:0]     timer_shadow;
    int                                  drain_cycles;

    pacman_pixel_top
    #(
        .NUM_GHOSTS    (NG),
        .FRIGHT_FRAMES (FRIGHT_FRAMES)
    )
    u_pacman_pixel_top
    (
        .frame_clk    (frame_clk),
        .reset        (reset),
        .draw         (draw),
        .hero         (hero),
        .hero_motion  (hero_motion),
        .ghost_pos    (ghost_pos),
        .ghost_motion (ghost_motion),
        .win          (win),
        .lose         (lose),
        .power_pellet (power_pellet),
        .capture      (capture),
        .pixel        (pixel),
        .fright       (fright)
    );

    always #10 frame_clk = ~frame_clk;

    task automatic value_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
        $display("[FAIL] %s got %h expected %h", name, got, exp);
        $display("STATUS: FAIL");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic fail_text(input string what);
        $display("%s", what);
        $display("STATUS: FAIL");
        $fatal(1, "stopped on error");
    endtask

    ////////////////////////////////////////
    // reference model

    // strict box so a distance of SPRITE_HALF misses
    function automatic logic near_box(input sprite_pos_t d, input sprite_pos_t p);
        int ax;
        int ay;
        ax = int'(d.x) - int'(p.x);
        ay = int'(d.y) - int'(p.y);
        return (ax > -SPRITE_HALF) && (ax < SPRITE_HALF) && (ay > -SPRITE_HALF)
            && (ay < SPRITE_HALF);
    endfunction

    function automatic logic ghost_kind(input ghost_motion_t m,
                                        input logic [FRIGHT_WIDTH-1:0] t,
                                        output sprite_kind_t kind);
        kind = blank;
        if (t != '0)
            kind = ghost_scared;
        else if (m.dx == STEP_NONE && m.dy == STEP_NONE)
            kind = (m.dx_prev == STEP_POS) ? ghost_right :
                   (m.dx_prev == STEP_NEG) ? ghost_left :
                   (m.dy_prev == STEP_POS) ? ghost_down : ghost_up;
        else if (m.dy == STEP_POS || m.dy_next == STEP_POS)
            kind = ghost_down;
        else if (m.dy == STEP_NEG || m.dy_next == STEP_NEG)
            kind = ghost_up;
        else if (m.dx == STEP_NEG || m.dx_next == STEP_NEG)
            kind = ghost_left;
        else if (m.dx == STEP_POS || m.dx_next == STEP_POS)
            kind = ghost_right;
        else
            return 1'b0;
        return 1'b1;
    endfunction

    function automatic rgb_t expected_pixel(
        input sprite_pos_t                     d,
        input sprite_pos_t                     h,
        input hero_motion_t                    hm,
        input sprite_pos_t [NG-1:0]            gp,
        input ghost_motion_t [NG-1:0]          gm,
        input logic                            w,
        input logic                            l,
        input int                              anim,
        input logic [NG-1:0][FRIGHT_WIDTH-1:0] tmr
    );
        sprite_kind_t kind;
        logic         alt;
        logic         found;
        logic         in_field;
        rgb_t         color;
        int           g;
        in_field = (int'(d.x) >= FIELD_X_MIN) && (int'(d.x) < FIELD_X_MAX);
        kind     = blank;
        alt      = 1'b0;
        found    = 1'b0;
        if ((w || l) && in_field)
        begin
            kind  = end_screen;
            found = 1'b1;
        end
        else if (near_box(d, h))
        begin
            found = 1'b1;
            alt   = (anim >= ANIM_HALF);
            if (hm.dx == STEP_POS || hm.dx_next == STEP_POS)
                kind = hero_right;
            else if (hm.dx == STEP_NEG || hm.dx_next == STEP_NEG)
                kind = hero_left;
            else if (hm.dy == STEP_NEG || hm.dy_next == STEP_NEG)
                kind = hero_up;
            else if (hm.dy == STEP_POS || hm.dy_next == STEP_POS)
                kind = hero_down;
            else
            begin
                kind = hero_down;
                alt  = 1'b0;
            end
        end
        for (g = 0; g < NG; g++)
        begin
            if (!found && near_box(d, gp[g]))
                found = ghost_kind(gm[g], tmr[g], kind);
        end
        if (!found)
            kind = in_field ? field : blank;
        color = kind_color[kind];
        if (alt)
            color.red = color.red >> ALT_FRAME_RED_SHIFT;
        return color;
    endfunction

    ////////////////////////////////////////
    // shadow state for the counter and timers

    always @(posedge frame_clk)
    begin
        if (reset)
        begin
            anim_shadow  <= 0;
            timer_shadow <= '0;
        end
        else
        begin
            anim_shadow <= (anim_shadow == ANIM_PERIOD - 1) ? 0 : anim_shadow + 1;
            for (int g = 0; g < NG; g++)
            begin
                if (power_pellet)
                    timer_shadow[g] <= FRIGHT_WIDTH'(FRIGHT_FRAMES);
                else if (capture[g])
                    timer_shadow[g] <= '0;
                else if (timer_shadow[g] != '0)
                    timer_shadow[g] <= timer_shadow[g] - 1'b1;
            end
        end
    end

    // compare one ns before the rising edge
    always @(negedge frame_clk)
    begin
        rgb_t exp_pixel;
        #9;
        if (!reset)
        begin
            for (int g = 0; g < NG; g++)
            begin
                assert (fright[g] === timer_shadow[g])
                else value_mismatch($sformatf("fright[%0d]", g), fright[g], timer_shadow[g]);
            end
            exp_pixel = expected_pixel(draw, hero, hero_motion, ghost_pos, ghost_motion,
                                       win, lose, anim_shadow, timer_shadow);
            assert (pixel === exp_pixel)
            else value_mismatch("pixel", pixel, exp_pixel);
        end
    end

    ////////////////////////////////////////
    // stimulus

    function automatic step_t rand_step();
        case ($urandom % 3)
            0:       return STEP_POS;
            1:       return STEP_NEG;
            default: return STEP_NONE;
        endcase
    endfunction

    // offsets reach one past the box edge on both sides
    function automatic sprite_pos_t place_sprite(input sprite_pos_t d, input logic near);
        sprite_pos_t p;
        if (near && ($urandom % 4 != 0))
        begin
            p.x = coord_t'(int'(d.x) + int'($urandom % (2 * SPRITE_HALF + 3)) - SPRITE_HALF - 1);
            p.y = coord_t'(int'(d.y) + int'($urandom % (2 * SPRITE_HALF + 3)) - SPRITE_HALF - 1);
        end
        else
        begin
            p.x = coord_t'(int'(d.x) + 40 + int'($urandom % 100));
            p.y = d.y;
        end
        return p;
    endfunction

    task automatic drive_scene(input logic near, input logic events);
        draw.x      = coord_t'($urandom % 640);
        draw.y      = coord_t'($urandom % 480);
        hero        = place_sprite(draw, near);
        hero_motion = '{rand_step(), rand_step(), rand_step(), rand_step()};
        for (int g = 0; g < NG; g++)
        begin
            ghost_pos[g]    = place_sprite(draw, near);
            ghost_motion[g] = '{rand_step(), rand_step(), rand_step(), rand_step(),
                                rand_step(), rand_step()};
            capture[g]      = events && ($urandom % 8 == 0);
        end
        win          = ($urandom % 8 == 0);
        lose         = !win && ($urandom % 8 == 0);
        power_pellet = events && ($urandom % 32 == 0);
    endtask

    initial
    begin
        void'($urandom(32'hf74));
        frame_clk    = 1'b0;
        reset        = 1'b1;
        draw         = '0;
        hero         = '0;
        hero_motion  = '0;
        ghost_pos    = '0;
        ghost_motion = '0;
        win          = 1'b0;
        lose         = 1'b0;
        power_pellet = 1'b0;
        capture      = '0;
        repeat (16) @(posedge frame_clk);
        @(negedge frame_clk);
        reset = 1'b0;

        // static layers only
        repeat (200)
        begin
            drive_scene(1'b0, 1'b0);
            @(negedge frame_clk);
        end
        // overlapping sprites with pellets and captures
        repeat (3000)
        begin
            drive_scene(1'b1, 1'b1);
            @(negedge frame_clk);
        end
        // let every timer count down to zero
        drain_cycles = 0;
        while (fright != '0)
        begin
            drive_scene(1'b1, 1'b0);
            @(negedge frame_clk);
            drain_cycles++;
            if (drain_cycles > DRAIN_LIMIT)
                fail_text("frightened timers did not reach zero in time");
        end
        repeat (100)
        begin
            drive_scene(1'b1, 1'b0);
            @(negedge frame_clk);
        end

        $display("STATUS: PASS");
        $finish;
    end

endmodule

/* vlog.f */
verilog/pac_pkg.sv
verilog/fright_timer_bank.sv
verilog/hero_sprite.sv
verilog/ghost_sprite.sv
verilog/pixel_compositor.sv
verilog/pacman_pixel_top.sv
bench/pixel_tb.sv
